/* fm_synth.f */
+incdir+verilog
verilog/fm_synth_pkg.sv
verilog/fm_reg_decode.sv
verilog/fm_envelope.sv
verilog/fm_waveform.sv
verilog/fm_operator_pipe.sv
verilog/fm_sample_mixer.sv
verilog/fm_synth.sv
tests/fm_synth_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fm_synth testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f fm_synth.f \
    --top-module fm_synth_tb -o fm_synth_sim
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

./obj_dir/fm_synth_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "run_sim: failure reported, see $LOG"
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "run_sim: no pass report in $LOG"
    exit 1
fi
echo "run_sim: simulation passed"
exit 0

/* tests/fm_synth_tb.sv */
`timescale 1ns/100ps
`include "fm_synth_consts.svh"

module fm_synth_tb;

    localparam int CLK_PERIOD     = 4;
    localparam int FRAME_CYCLES   = `FM_SLOTS;
    localparam int SAMPLE_TIMEOUT = FRAME_CYCLES + `FM_PIPE_DEPTH + 4;

    // Budgets per test in frames
    localparam int SILENT_COUNT   = 8;
    localparam int WRITE_FRAMES   = 8;
    localparam int SETTLE_FRAMES  = 400;
    localparam int SETTLE_RUN     = 6;
    localparam int STEADY_COUNT   = 8;
    localparam int PULSE_COUNT    = 8;
    localparam int PULSE_FRAMES   = PULSE_COUNT + 2;
    localparam int STALL_FRAMES   = 6;
    localparam int RELEASE_FRAMES = 200;
    localparam int MARGIN_FRAMES  = 32;
    localparam int TEST_FRAMES    = SILENT_COUNT + 2 + WRITE_FRAMES + SETTLE_FRAMES
                                  + STEADY_COUNT + PULSE_FRAMES + STALL_FRAMES + WRITE_FRAMES
                                  + STEADY_COUNT + RELEASE_FRAMES + STEADY_COUNT;
    localparam int WATCHDOG_NS    = (TEST_FRAMES + MARGIN_FRAMES) * FRAME_CYCLES * CLK_PERIOD;

    // Address fields
    localparam logic [1:0] SCOPE_OPER  = 2'b11;
    localparam logic [1:0] SCOPE_VOICE = 2'b10;
    localparam logic [5:0] P_PHASE_HI  = 6'h00;
    localparam logic [5:0] P_PHASE_LO  = 6'h01;
    localparam logic [5:0] P_WAVE      = 6'h02;
    localparam logic [5:0] P_ATTACK    = 6'h03;
    localparam logic [5:0] P_DECAY     = 6'h04;
    localparam logic [5:0] P_SUSTAIN   = 6'h05;
    localparam logic [5:0] P_RELEASE   = 6'h06;
    localparam logic [5:0] P_NOTE      = 6'h00;

    logic               i_Clock;
    logic               i_rst_n;
    logic               i_reg_valid;
    logic [15:0]        i_reg_addr;
    logic [7:0]         i_reg_data;
    logic               i_sample_ready;
    logic signed [15:0] o_sample;
    logic               o_sample_valid;
    logic               o_overrun;

    int          errors;
    int          test_start_errors;
    int          tests_ok;
    int          tests_bad;
    logic [31:0] rng_state;

    fm_synth UUT (
        .i_Clock        (i_Clock),
        .i_rst_n        (i_rst_n),
        .i_reg_valid    (i_reg_valid),
        .i_reg_addr     (i_reg_addr),
        .i_reg_data     (i_reg_data),
        .i_sample_ready (i_sample_ready),
        .o_sample       (o_sample),
        .o_sample_valid (o_sample_valid),
        .o_overrun      (o_overrun)
    );

    initial begin
        i_Clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_Clock = ~i_Clock;
    end

    // Ends a run that stalls
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Steady sample of ops square carriers at phase 0 and sustain level sus
    function automatic int steady_sample(input logic [7:0] sus, input int ops);
        int level;
        int slot_val;
        int sum;
        level    = int'(sus) * 32;
        slot_val = (32767 * level) >>> 13;
        sum      = ops * slot_val;
        return sum >>> 5;
    endfunction

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("error at %0d ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic expect_equal(input string name, input int got, input int want);
        assert (got == want) else begin
            $display("mismatch at %0d ns: %s expected %0d, got %0d", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start_errors) begin
            tests_ok++;
            $display("done: %s, ok", name);
        end else begin
            tests_bad++;
            $display("done: %s, %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // Random idle gap of 0 to 3 cycles
    task automatic idle_gap();
        int gap;
        rng_state = next_random(rng_state);
        gap = int'(rng_state[1:0]);
        repeat (gap) @(posedge i_Clock);
    endtask

    task automatic write_reg(input logic [1:0] scope, input logic [5:0] param,
                             input logic [2:0] oper, input logic [4:0] voice,
                             input logic [7:0] data);
        @(posedge i_Clock);
        i_reg_valid <= 1'b1;
        i_reg_addr  <= {scope, param, oper, voice};
        i_reg_data  <= data;
        @(posedge i_Clock);
        i_reg_valid <= 1'b0;
        idle_gap();
    endtask

    task automatic configure_operator(input logic [2:0] oper, input logic [4:0] voice,
                                      input logic [7:0] wave, input logic [15:0] step,
                                      input logic [7:0] rate, input logic [7:0] sus);
        write_reg(SCOPE_OPER, P_PHASE_HI, oper, voice, step[15:8]);
        write_reg(SCOPE_OPER, P_PHASE_LO, oper, voice, step[7:0]);
        write_reg(SCOPE_OPER, P_WAVE, oper, voice, wave);
        write_reg(SCOPE_OPER, P_ATTACK, oper, voice, rate);
        write_reg(SCOPE_OPER, P_DECAY, oper, voice, rate);
        write_reg(SCOPE_OPER, P_SUSTAIN, oper, voice, sus);
        write_reg(SCOPE_OPER, P_RELEASE, oper, voice, rate);
    endtask

    // Next accepted sample as seen on the falling edge
    task automatic wait_sample(output logic signed [15:0] value);
        int waited;
        waited = 0;
        @(negedge i_Clock);
        while (!(o_sample_valid && i_sample_ready) && waited < SAMPLE_TIMEOUT) begin
            @(negedge i_Clock);
            waited++;
        end
        expect_true(waited < SAMPLE_TIMEOUT, "no sample arrived within the timeout");
        value = o_sample;
    endtask

    // Waits for a run of samples at want that outlasts an envelope step
    task automatic settle_on(input int want, input int limit, input string what);
        logic signed [15:0] value;
        int frames;
        int run;
        frames = 0;
        run    = 0;
        while (run < SETTLE_RUN && frames < limit) begin
            wait_sample(value);
            run = (int'(value) == want) ? run + 1 : 0;
            frames++;
        end
        expect_true(run >= SETTLE_RUN, what);
    endtask

    task automatic check_steady(input int want, input int count);
        logic signed [15:0] value;
        for (int i = 0; i < count; i++) begin
            wait_sample(value);
            expect_equal("o_sample", int'(value), want);
        end
    endtask

    // Valid pulses with ready high
    task automatic check_pulse_spacing();
        int cycle;
        int last_rise;
        int rises;
        logic prev_valid;
        cycle      = 0;
        last_rise  = -1;
        rises      = 0;
        prev_valid = 1'b0;
        while (rises < PULSE_COUNT && cycle < PULSE_FRAMES * FRAME_CYCLES) begin
            @(negedge i_Clock);
            if (o_sample_valid) begin
                expect_true(!prev_valid, "sample valid held longer than one cycle");
                if (last_rise >= 0) begin
                    expect_equal("o_sample_valid spacing", cycle - last_rise, FRAME_CYCLES);
                end
                last_rise = cycle;
                rises++;
            end
            prev_valid = o_sample_valid;
            cycle++;
        end
        expect_true(rises == PULSE_COUNT, "too few sample valid pulses");
    endtask

    // Ready low past a frame before the held sample is accepted
    task automatic check_backpressure(input int want);
        logic signed [15:0] held;
        int waited;
        waited = 0;
        @(posedge i_Clock);
        i_sample_ready <= 1'b0;
        @(negedge i_Clock);
        while (!o_sample_valid && waited < SAMPLE_TIMEOUT) begin
            @(negedge i_Clock);
            waited++;
        end
        expect_true(o_sample_valid, "no sample offered while ready was low");
        held = o_sample;
        expect_equal("o_sample", int'(held), want);
        for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
            @(negedge i_Clock);
            expect_true(o_sample_valid, "sample valid dropped while ready was low");
            expect_equal("o_sample", int'(o_sample), int'(held));
        end
        expect_true(o_overrun, "overrun not raised after a dropped frame");
        @(posedge i_Clock);
        i_sample_ready <= 1'b1;
        // Held sample is taken on this edge
        @(posedge i_Clock);
        waited = 0;
        do begin
            @(negedge i_Clock);
            waited++;
        end while (!o_sample_valid && waited < 2 * FRAME_CYCLES);
        expect_true(waited <= FRAME_CYCLES, "next sample later than one frame after acceptance");
        expect_true(o_overrun, "overrun cleared without reset");
    endtask

    initial begin
        logic [7:0] sustain;
        int         expected;
        i_rst_n        <= 1'b0;
        i_reg_valid    <= 1'b0;
        i_reg_addr     <= '0;
        i_reg_data     <= '0;
        i_sample_ready <= 1'b1;
        errors            = 0;
        test_start_errors = 0;
        tests_ok          = 0;
        tests_bad         = 0;
        rng_state         = 32'ha6c9;
        repeat (3) @(posedge i_Clock);
        i_rst_n <= 1'b1;

        // Quiet outputs and silence with all notes off
        @(negedge i_Clock);
        expect_true(!o_sample_valid, "sample valid high right after reset");
        expect_true(!o_overrun, "overrun high right after reset");
        check_steady(0, SILENT_COUNT);
        finish_test("reset and silence");

        // Voice 0 with four square carriers at phase 0
        rng_state = next_random(rng_state);
        sustain   = 8'd48 + 8'(rng_state[6:0]);
        expected  = steady_sample(sustain, `FM_OPERATORS);
        for (int op = 0; op < `FM_OPERATORS; op++) begin
            configure_operator(3'(op), 5'd0, {6'b0, fm_synth_pkg::WAVE_SQUARE}, 16'h0000,
                               8'd255, sustain);
        end
        write_reg(SCOPE_VOICE, P_NOTE, 3'd0, 5'd0, 8'h01);
        settle_on(expected, SETTLE_FRAMES, "tone did not settle at the sustain level");
        check_steady(expected, STEADY_COUNT);
        finish_test("sustained square tone");

        check_pulse_spacing();
        finish_test("sample valid spacing");

        check_backpressure(expected);
        finish_test("back-pressure and overrun");

        // Writes that must decode to nothing
        write_reg(2'b00, P_SUSTAIN, 3'd0, 5'd0, 8'h00);
        write_reg(2'b01, P_WAVE, 3'd0, 5'd0, 8'h00);
        write_reg(SCOPE_VOICE, 6'h01, 3'd0, 5'd0, 8'h00);
        write_reg(SCOPE_OPER, 6'h07, 3'd0, 5'd0, 8'h00);
        for (int op = 4; op < 8; op++) begin
            write_reg(SCOPE_OPER, P_WAVE, 3'(op), 5'd0, 8'h00);
            write_reg(SCOPE_OPER, P_SUSTAIN, 3'(op), 5'd0, 8'h00);
            write_reg(SCOPE_OPER, P_PHASE_HI, 3'(op), 5'd0, 8'h80);
        end
        // Voice 8 would alias voice 0 in the low slot bits
        write_reg(SCOPE_OPER, P_WAVE, 3'd0, 5'd8, 8'h00);
        write_reg(SCOPE_VOICE, P_NOTE, 3'd0, 5'd8, 8'h00);
        check_steady(expected, STEADY_COUNT);
        finish_test("reserved and out of range writes");

        // Note off releases to silence
        write_reg(SCOPE_VOICE, P_NOTE, 3'd0, 5'd0, 8'h00);
        settle_on(0, RELEASE_FRAMES, "samples did not fall to zero after note off");
        check_steady(0, STEADY_COUNT);
        finish_test("release after note off");

        $display("closing count: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/fm_synth.sv */
`timescale 1ns/100ps

module fm_synth (
    input  logic               i_Clock,
    input  logic               i_rst_n,
    input  logic               i_reg_valid,
    input  logic [15:0]        i_reg_addr,
    input  logic [7:0]         i_reg_data,
    input  logic               i_sample_ready,
    output logic signed [15:0] o_sample,
    output logic               o_sample_valid,
    output logic               o_overrun
);

    fm_synth_pkg::reg_write_t write_cmd;
    fm_synth_pkg::slot_out_t  slot_out;

    // Address decode, one cycle
    fm_reg_decode u_decode (
        .i_Clock     (i_Clock),
        .i_rst_n     (i_rst_n),
        .i_reg_valid (i_reg_valid),
        .i_reg_addr  (i_reg_addr),
        .i_reg_data  (i_reg_data),
        .o_write     (write_cmd)
    );

    // Slot processing
    fm_operator_pipe u_pipe (
        .i_Clock (i_Clock),
        .i_rst_n (i_rst_n),
        .i_write (write_cmd),
        .o_slot  (slot_out)
    );

    // Frame sum and sample handshake
    fm_sample_mixer u_mixer (
        .i_Clock        (i_Clock),
        .i_rst_n        (i_rst_n),
        .i_slot         (slot_out),
        .i_sample_ready (i_sample_ready),
        .o_sample       (o_sample),
        .o_sample_valid (o_sample_valid),
        .o_overrun      (o_overrun)
    );

endmodule

/* verilog/fm_sample_mixer.sv */
`timescale 1ns/100ps
`include "fm_synth_consts.svh"

module fm_sample_mixer (
    input  logic                    i_Clock,
    input  logic                    i_rst_n,
    input  fm_synth_pkg::slot_out_t i_slot,
    input  logic                    i_sample_ready,
    output logic signed [15:0]      o_sample,
    output logic                    o_sample_valid,
    output logic                    o_overrun
);

    // 21 bits hold 32 full-scale slots
    logic signed [20:0] acc;
    logic signed [20:0] slot_ext;
    logic signed [20:0] sum_next;
    logic               frame_done;

    assign slot_ext = {{5{i_slot.value[15]}}, i_slot.value};

    // Slot 0 restarts the sum
    assign sum_next = (i_slot.slot == '0) ? slot_ext : acc + slot_ext;

    assign frame_done = i_slot.valid && (i_slot.slot == `FM_SLOT_W'(`FM_SLOTS - 1));

    always_ff @(posedge i_Clock) begin
        if (i_slot.valid) begin
            acc <= sum_next;
        end
    end

    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            o_sample_valid <= 1'b0;
            o_overrun      <= 1'b0;
        end else if (frame_done) begin
            if (!o_sample_valid || i_sample_ready) begin
                // Bits 20:5 are the sum shifted right by 5
                o_sample       <= sum_next[20:5];
                o_sample_valid <= 1'b1;
            end else begin
                // Held sample stays, new frame is lost
                o_overrun <= 1'b1;
            end
        end else if (i_sample_ready) begin
            o_sample_valid <= 1'b0;
        end
    end

    // Stalled sample holds value and valid
    a_hold_stable: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_sample_valid && !i_sample_ready |=> o_sample_valid && $stable(o_sample));

endmodule

/* verilog/fm_operator_pipe.sv */
`timescale 1ns/100ps
`include "fm_synth_consts.svh"

module fm_operator_pipe (
    input  logic                     i_Clock,
    input  logic                     i_rst_n,
    input  fm_synth_pkg::reg_write_t i_write,
    output fm_synth_pkg::slot_out_t  o_slot
);

    localparam int DIV_W   = $clog2(`FM_ENV_DIV);
    localparam int VOICE_W = $clog2(`FM_VOICES);

    // Slot counter and frame divider
    logic [`FM_SLOT_W-1:0] slot_cnt;
    logic [DIV_W-1:0]      frame_div;
    logic                  env_step;

    // Per-slot configuration
    logic [15:0]         phase_step    [`FM_SLOTS];
    fm_synth_pkg::wave_t wave_sel      [`FM_SLOTS];
    logic [7:0]          attack_rate   [`FM_SLOTS];
    logic [7:0]          decay_rate    [`FM_SLOTS];
    logic [7:0]          sustain_level [`FM_SLOTS];
    logic [7:0]          release_rate  [`FM_SLOTS];
    logic                note_on       [`FM_VOICES];
    logic [15:0]         phase_acc     [`FM_SLOTS];

    // Pipeline registers named by stage suffix
    logic [15:0]           phase_s1;
    fm_synth_pkg::wave_t   wave_s1;
    logic [12:0]           level_s1;
    logic signed [15:0]    wave_val_s2;
    logic [12:0]           level_s2;
    logic signed [29:0]    product_s3;
    logic [`FM_SLOT_W-1:0] slot_s1;
    logic [`FM_SLOT_W-1:0] slot_s2;
    logic [`FM_SLOT_W-1:0] slot_s3;
    logic                  valid_s1;
    logic                  valid_s2;
    logic                  valid_s3;

    // Envelope steps during every FM_ENV_DIV-th frame
    assign env_step = (frame_div == DIV_W'(`FM_ENV_DIV - 1));

    // Register writes
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `FM_SLOTS; i++) begin
                phase_step[i]    <= '0;
                wave_sel[i]      <= fm_synth_pkg::WAVE_OFF;
                attack_rate[i]   <= '0;
                decay_rate[i]    <= '0;
                sustain_level[i] <= '0;
                release_rate[i]  <= '0;
            end
            for (int v = 0; v < `FM_VOICES; v++) begin
                note_on[v] <= 1'b0;
            end
        end else if (i_write.valid) begin
            case (i_write.op)
                fm_synth_pkg::PHASE_HI:      phase_step[i_write.slot][15:8] <= i_write.data;
                fm_synth_pkg::PHASE_LO:      phase_step[i_write.slot][7:0] <= i_write.data;
                fm_synth_pkg::WAVE:
                    wave_sel[i_write.slot] <= fm_synth_pkg::wave_t'(i_write.data[1:0]);
                fm_synth_pkg::ATTACK_RATE:   attack_rate[i_write.slot] <= i_write.data;
                fm_synth_pkg::DECAY_RATE:    decay_rate[i_write.slot] <= i_write.data;
                fm_synth_pkg::SUSTAIN_LEVEL: sustain_level[i_write.slot] <= i_write.data;
                fm_synth_pkg::RELEASE_RATE:  release_rate[i_write.slot] <= i_write.data;
                // Voice is the low slot bits
                fm_synth_pkg::NOTE_ON:
                    note_on[i_write.slot[VOICE_W-1:0]] <= i_write.data[0];
                default: ;
            endcase
        end
    end

    // Stage 0 issues the slot and advances its phase once per frame
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            slot_cnt  <= '0;
            frame_div <= '0;
            for (int i = 0; i < `FM_SLOTS; i++) begin
                phase_acc[i] <= '0;
            end
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
            if (slot_cnt == `FM_SLOT_W'(`FM_SLOTS - 1)) begin
                frame_div <= (env_step) ? '0 : frame_div + 1'b1;
            end
            phase_acc[slot_cnt] <= phase_acc[slot_cnt] + phase_step[slot_cnt];
        end
    end

    // Stage 1 payload
    always_ff @(posedge i_Clock) begin
        phase_s1 <= phase_acc[slot_cnt];
        wave_s1  <= wave_sel[slot_cnt];
        slot_s1  <= slot_cnt;
    end

    // Envelope level arrives aligned with stage 1
    fm_envelope u_envelope (
        .i_Clock         (i_Clock),
        .i_rst_n         (i_rst_n),
        .i_slot          (slot_cnt),
        .i_step          (env_step),
        .i_note_on       (note_on[slot_cnt[VOICE_W-1:0]]),
        .i_attack_rate   (attack_rate[slot_cnt]),
        .i_decay_rate    (decay_rate[slot_cnt]),
        .i_sustain_level (sustain_level[slot_cnt]),
        .i_release_rate  (release_rate[slot_cnt]),
        .o_level         (level_s1)
    );

    // Stage 2 waveform value
    fm_waveform u_waveform (
        .i_Clock (i_Clock),
        .i_phase (phase_s1),
        .i_wave  (wave_s1),
        .o_value (wave_val_s2)
    );

    // Stages 2 to 4 align the level, multiply, then scale
    always_ff @(posedge i_Clock) begin
        level_s2   <= level_s1;
        slot_s2    <= slot_s1;
        product_s3 <= wave_val_s2 * $signed({1'b0, level_s2});
        slot_s3    <= slot_s2;
        o_slot.slot <= slot_s3;
        // Bits 28:13 are the product shifted right by 13
        o_slot.value <= product_s3[28:13];
    end

    // Valid marks slots issued since reset
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            valid_s1     <= 1'b0;
            valid_s2     <= 1'b0;
            valid_s3     <= 1'b0;
            o_slot.valid <= 1'b0;
        end else begin
            valid_s1     <= 1'b1;
            valid_s2     <= valid_s1;
            valid_s3     <= valid_s2;
            o_slot.valid <= valid_s3;
        end
    end

    // Slot tag and its value both come from the slot issued FM_PIPE_DEPTH clocks back
    // A slot issued with its waveform off must arrive silent
    a_slot_delay: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_slot.valid |-> o_slot.slot == $past(slot_cnt, `FM_PIPE_DEPTH)
            && ($past(wave_s1, `FM_PIPE_DEPTH - 1) != fm_synth_pkg::WAVE_OFF
                || o_slot.value == '0));

endmodule

/* verilog/fm_waveform.sv */
`timescale 1ns/100ps

module fm_waveform (
    input  logic                i_Clock,
    input  logic [15:0]         i_phase,
    input  fm_synth_pkg::wave_t i_wave,
    output logic signed [15:0]  o_value
);

    logic signed [15:0] saw;
    logic signed [15:0] square;
    logic signed [16:0] tri_wide;
    logic [14:0]        fold;

    // Saw is phase minus half scale, so flip the top bit
    assign saw = {~i_phase[15], i_phase[14:0]};

    // Symmetric square, no -32768
    assign square = i_phase[15] ? -16'sd32767 : 16'sd32767;

    // Fold the second half back down
    assign fold = i_phase[15] ? ~i_phase[14:0] : i_phase[14:0];

    // Twice the fold minus 32767 spans +/-32767
    assign tri_wide = $signed({1'b0, fold, 1'b0}) - 17'sd32767;

    always_ff @(posedge i_Clock) begin
        case (i_wave)
            fm_synth_pkg::WAVE_SAW:    o_value <= saw;
            fm_synth_pkg::WAVE_SQUARE: o_value <= square;
            fm_synth_pkg::WAVE_TRI:    o_value <= tri_wide[15:0];
            default:                   o_value <= '0;
        endcase
    end

endmodule

/* verilog/fm_envelope.sv */
`timescale 1ns/100ps
`include "fm_synth_consts.svh"

module fm_envelope (
    input  logic                  i_Clock,
    input  logic                  i_rst_n,
    input  logic [`FM_SLOT_W-1:0] i_slot,
    input  logic                  i_step,
    input  logic                  i_note_on,
    input  logic [7:0]            i_attack_rate,
    input  logic [7:0]            i_decay_rate,
    input  logic [7:0]            i_sustain_level,
    input  logic [7:0]            i_release_rate,
    output logic [12:0]           o_level
);

    // Per-slot state and level
    fm_synth_pkg::env_state_t state_mem [`FM_SLOTS];
    logic [12:0]              level_mem [`FM_SLOTS];

    fm_synth_pkg::env_state_t state_cur;
    fm_synth_pkg::env_state_t state_nxt;
    logic [12:0]              level_cur;
    logic [12:0]              level_nxt;
    logic [12:0]              target;
    logic [13:0]              attack_sum;

    assign state_cur = state_mem[i_slot];
    assign level_cur = level_mem[i_slot];

    // Sustain target is the 8-bit level in the top bits
    assign target = {i_sustain_level, 5'b0};

    // One extra bit to catch overflow past the ceiling
    assign attack_sum = {1'b0, level_cur} + {6'b0, i_attack_rate};

    always_comb begin
        state_nxt = state_cur;
        level_nxt = level_cur;
        case (state_cur)
            fm_synth_pkg::ENV_ATTACK: begin
                if (!i_note_on) begin
                    state_nxt = fm_synth_pkg::ENV_RELEASE;
                end else if (level_cur == `FM_ENV_MAX) begin
                    state_nxt = fm_synth_pkg::ENV_DECAY;
                end else if (i_step) begin
                    // Saturate at the ceiling
                    level_nxt = (attack_sum > `FM_ENV_MAX) ? `FM_ENV_MAX : attack_sum[12:0];
                end
            end
            fm_synth_pkg::ENV_DECAY: begin
                if (!i_note_on) begin
                    state_nxt = fm_synth_pkg::ENV_RELEASE;
                end else if (level_cur <= target) begin
                    state_nxt = fm_synth_pkg::ENV_SUSTAIN;
                end else if (i_step) begin
                    // Clamp at the sustain target
                    if (level_cur - target < {5'b0, i_decay_rate}) begin
                        level_nxt = target;
                    end else begin
                        level_nxt = level_cur - {5'b0, i_decay_rate};
                    end
                end
            end
            fm_synth_pkg::ENV_SUSTAIN: begin
                if (!i_note_on) begin
                    state_nxt = fm_synth_pkg::ENV_RELEASE;
                end else if (i_step) begin
                    level_nxt = target;
                end
            end
            fm_synth_pkg::ENV_RELEASE: begin
                if (level_cur == '0) begin
                    state_nxt = fm_synth_pkg::ENV_MUTE;
                end else if (i_step) begin
                    // Floor at zero
                    if ({5'b0, i_release_rate} > level_cur) begin
                        level_nxt = '0;
                    end else begin
                        level_nxt = level_cur - {5'b0, i_release_rate};
                    end
                end
            end
            default: begin
                // Mute stays silent until note on
                level_nxt = '0;
                if (i_note_on) begin
                    state_nxt = fm_synth_pkg::ENV_ATTACK;
                end
            end
        endcase
    end

    // Write back the addressed slot and send its level one cycle later
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `FM_SLOTS; i++) begin
                state_mem[i] <= fm_synth_pkg::ENV_MUTE;
                level_mem[i] <= '0;
            end
            o_level <= '0;
        end else begin
            state_mem[i_slot] <= state_nxt;
            level_mem[i_slot] <= level_nxt;
            o_level           <= level_nxt;
        end
    end

    // Attack stops at the ceiling and never wraps past it
    a_level_max: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        state_cur == fm_synth_pkg::ENV_ATTACK |-> level_nxt >= level_cur);

    // A slot read back in mute was left there at level zero
    a_mute_zero: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        state_cur == fm_synth_pkg::ENV_MUTE |-> level_cur == '0);

endmodule

/* verilog/fm_reg_decode.sv */
`timescale 1ns/100ps
`include "fm_synth_consts.svh"

module fm_reg_decode (
    input  logic                     i_Clock,
    input  logic                     i_rst_n,
    input  logic                     i_reg_valid,
    input  logic [15:0]              i_reg_addr,
    input  logic [7:0]               i_reg_data,
    output fm_synth_pkg::reg_write_t o_write
);

    // Address fields: scope, parameter, operator, voice
    logic [1:0] scope;
    logic [5:0] param;
    logic [2:0] oper;
    logic [4:0] voice;
    logic       oper_ok;
    logic       voice_ok;

    fm_synth_pkg::reg_op_t op;

    assign scope = i_reg_addr[15:14];
    assign param = i_reg_addr[13:8];
    assign oper  = i_reg_addr[7:5];
    assign voice = i_reg_addr[4:0];

    // Only operators 0..3 and voices 0..7 exist
    assign oper_ok  = (oper < `FM_OPERATORS);
    assign voice_ok = (voice < `FM_VOICES);

    always_comb begin
        op = fm_synth_pkg::NONE;
        if (scope == 2'b11 && oper_ok && voice_ok) begin
            // Operator scope
            case (param)
                6'h00:   op = fm_synth_pkg::PHASE_HI;
                6'h01:   op = fm_synth_pkg::PHASE_LO;
                6'h02:   op = fm_synth_pkg::WAVE;
                6'h03:   op = fm_synth_pkg::ATTACK_RATE;
                6'h04:   op = fm_synth_pkg::DECAY_RATE;
                6'h05:   op = fm_synth_pkg::SUSTAIN_LEVEL;
                6'h06:   op = fm_synth_pkg::RELEASE_RATE;
                default: op = fm_synth_pkg::NONE;
            endcase
        end else if (scope == 2'b10 && param == 6'h00 && voice_ok) begin
            // Voice scope, operator field is don't care
            op = fm_synth_pkg::NOTE_ON;
        end
    end

    // Register the command, storage sees it one cycle later
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            o_write.valid <= 1'b0;
            o_write.op    <= fm_synth_pkg::NONE;
        end else begin
            o_write.valid <= i_reg_valid;
            o_write.op    <= op;
        end
        // Slot packs as {operator, voice}
        o_write.slot <= {oper[1:0], voice[2:0]};
        o_write.data <= i_reg_data;
    end

endmodule

/* verilog/fm_synth_pkg.sv */
`include "fm_synth_consts.svh"

package fm_synth_pkg;

    // Register write opcodes after address decode
    typedef enum logic [3:0] {
        PHASE_HI,
        PHASE_LO,
        WAVE,
        ATTACK_RATE,
        DECAY_RATE,
        SUSTAIN_LEVEL,
        RELEASE_RATE,
        NOTE_ON,
        NONE
    } reg_op_t;

    // Waveform kinds, encoded as data bits [1:0] of a WAVE write
    typedef enum logic [1:0] {
        WAVE_OFF,
        WAVE_SAW,
        WAVE_SQUARE,
        WAVE_TRI
    } wave_t;

    // Envelope FSM states
    typedef enum logic [2:0] {
        ENV_MUTE,
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_t;

    // One decoded register write
    typedef struct packed {
        logic                  valid;
        reg_op_t               op;
        logic [`FM_SLOT_W-1:0] slot;
        logic [7:0]            data;
    } reg_write_t;

    // One slot result on its way to the mixer
    typedef struct packed {
        logic                  valid;
        logic [`FM_SLOT_W-1:0] slot;
        logic signed [15:0]    value;
    } slot_out_t;

endpackage

/* verilog/fm_synth_consts.svh */
`ifndef FM_SYNTH_CONSTS_SVH
`define FM_SYNTH_CONSTS_SVH

// Voice layout
`define FM_VOICES     8
`define FM_OPERATORS  4

// One slot per clock, so one frame is 32 clocks
`define FM_SLOTS      32

// Slot index is {operator[1:0], voice[2:0]}
`define FM_SLOT_W     5

// Frames between envelope level steps
`define FM_ENV_DIV    4

// 13-bit envelope ceiling
`define FM_ENV_MAX    13'd8191

// Issue to mixer latency in clocks
`define FM_PIPE_DEPTH 4

`endif
